//--- netdbg_stim.txt
// columns: tag nibble, then a 32-bit word; tag 1 gpio inputs, 2 request word,
// 3 last request word, 4 expected reply word, 5 expected last reply word, f end
// 1 header only
1_00000050
3_11110FA3
4_11115003
5_00000001
// 2 write then read back
1_00000000
2_22220000
2_80000003
2_12345678
3_40000003
4_22220003
4_11110002
5_12345678
// 3 bus error
1_00000000
2_33330000
3_60000005
4_33330003
4_22220003
5_DEADBEEF
// 4 error shown, header sets bit 2
1_00000000
3_44440404
4_44440407
5_33330004
// 5 error cleared, read times out
1_00000000
2_55550400
3_50000006
4_55550003
4_44440005
5_DEAD0000
// 6 several reads with nop and reserved
1_00000021
2_6666F090
2_40000001
2_00000000
2_40000005
2_C0000002
2_40000003
3_4000000F
4_66662193
4_55550006
4_C0DE0101
4_C0DE0505
4_12345678
5_C0DE0F0F
// 7 write opcode without its data word
1_00000000
2_77770000
2_40000009
3_80000009
4_77770093
4_66660007
5_C0DE0909
// 8 address 9 still holds its old value
1_00000000
2_88880000
3_40000009
4_88880093
4_77770008
5_C0DE0909
F_00000000

//--- files.f
netdbg_pkg.sv
dbg_rx_header.sv
dbg_bus_exec.sv
dbg_result_fifo.sv
dbg_tx_framer.sv
netdbg_top.sv
tb_clkgen.sv
tb_netdbg.sv

//--- tb_netdbg.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////
// debug bridge testbench that replays the stim packets,
// models a wishbone slave and checks every reply word
//////////////////////////////////////////////////
module tb_netdbg;
	import netdbg_pkg::*;

	localparam int LGWD = 6;
	localparam int STIM_DEPTH = 256;
	localparam int MAX_REPLY = 16;
	// bound on cycles per stim word that covers stalls and gaps
	localparam int CYC_PER_WORD = 50;

	// stim line tags in the top nibble of each entry
	localparam logic [3:0] TAG_GPIO = 4'h1;
	localparam logic [3:0] TAG_REQ = 4'h2;
	localparam logic [3:0] TAG_REQ_LAST = 4'h3;
	localparam logic [3:0] TAG_EXP = 4'h4;
	localparam logic [3:0] TAG_EXP_LAST = 4'h5;
	localparam logic [3:0] TAG_END = 4'hF;

	logic i_clk, i_reset;
	logic i_s_valid, o_s_ready, i_s_last;
	dbg_word_t i_s_data;
	logic o_m_valid, i_m_ready, o_m_last;
	dbg_word_t o_m_data;
	logic o_wb_cyc, o_wb_stb, o_wb_we;
	logic [29:0] o_wb_addr;
	dbg_word_t o_wb_data, i_wb_data;
	logic i_wb_stall, i_wb_ack, i_wb_err;
	gpio_t i_gpio, o_gpio;

	logic [35:0] stim [STIM_DEPTH];
	dbg_word_t mem [16];
	// received reply words as {last, data}
	logic [32:0] got_q [$];
	int replies_done, cycles, cycle_limit;
	int errors, n_pass, n_fail;
	logic [31:0] lcg_state;

	// slave side of the current bus cycle
	logic sl_busy, sl_we;
	int sl_wait;
	logic [29:0] sl_addr;
	dbg_word_t sl_data;

	tb_clkgen #(.PERIOD(40), .RESET_CYCLES(4)) u_clkgen (
		.o_clk(i_clk),
		.o_reset(i_reset)
	);

	netdbg_top #(.LGWATCHDOG(LGWD)) DUT (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_s_valid(i_s_valid), .o_s_ready(o_s_ready),
		.i_s_data(i_s_data), .i_s_last(i_s_last),
		.o_m_valid(o_m_valid), .i_m_ready(i_m_ready),
		.o_m_data(o_m_data), .o_m_last(o_m_last),
		.o_wb_cyc(o_wb_cyc), .o_wb_stb(o_wb_stb), .o_wb_we(o_wb_we),
		.o_wb_addr(o_wb_addr), .o_wb_data(o_wb_data),
		.i_wb_stall(i_wb_stall), .i_wb_ack(i_wb_ack),
		.i_wb_data(i_wb_data), .i_wb_err(i_wb_err),
		.i_gpio(i_gpio), .o_gpio(o_gpio)
	);

	// linear congruential generator that returns its upper bits
	function automatic logic [15:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[30:15];
	endfunction

	// offer one request word and wait for its transfer
	task automatic send_word(input dbg_word_t word, input logic last);
		i_s_valid <= 1'b1;
		i_s_data <= word;
		i_s_last <= last;
		@(posedge i_clk);
		while (!o_s_ready)
			@(posedge i_clk);
	endtask

	//////////////////////////////////////////////////
	// wishbone slave and reply back-pressure
	always @(posedge i_clk)
	begin
		if (i_reset)
		begin
			i_wb_stall <= 1'b0;
			i_wb_ack <= 1'b0;
			i_wb_err <= 1'b0;
			i_m_ready <= 1'b0;
			sl_busy = 1'b0;
		end
		else
		begin
			i_wb_ack <= 1'b0;
			i_wb_err <= 1'b0;
			i_wb_stall <= (lcg_next() % 3) == 0;
			i_m_ready <= (lcg_next() % 4) != 0;
			// request taken on this edge gets its answer after a random delay
			if (o_wb_cyc && o_wb_stb && !i_wb_stall)
			begin
				sl_busy = 1'b1;
				sl_wait = lcg_next() % 4;
				sl_addr = o_wb_addr;
				sl_we = o_wb_we;
				sl_data = o_wb_data;
			end
			else if (sl_busy && sl_wait > 0)
				sl_wait = sl_wait - 1;
			if (sl_busy && sl_wait == 0)
			begin
				sl_busy = 1'b0;
				// bit 29 answers with err and bit 28 never answers
				if (sl_addr[29])
					i_wb_err <= 1'b1;
				else if (!sl_addr[28])
				begin
					i_wb_ack <= 1'b1;
					if (sl_we)
						mem[sl_addr[3:0]] = sl_data;
					else
						i_wb_data <= mem[sl_addr[3:0]];
				end
			end
		end
	end

	// reply collector
	always @(posedge i_clk)
		if (!i_reset && o_m_valid && i_m_ready)
		begin
			got_q.push_back({o_m_last, o_m_data});
			if (o_m_last)
				replies_done++;
		end

	// run limit
	always @(posedge i_clk)
	begin
		cycles++;
		if (cycle_limit > 0 && cycles > cycle_limit)
		begin
			$display("ERROR: timeout, the bridge stopped answering after %0d cycles", cycles);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// test sequence
	initial
	begin
		int p, t, i, n_exp, n_words, fails_before;
		logic [32:0] exp_w [MAX_REPLY];
		logic [32:0] got;
		logic first;
		logic [3:0] tag;
		dbg_word_t w;
		gpio_t model_gpio;

		i_s_valid = 1'b0;
		i_s_data = '0;
		i_s_last = 1'b0;
		i_gpio = '0;
		i_m_ready = 1'b0;
		i_wb_stall = 1'b0;
		i_wb_ack = 1'b0;
		i_wb_err = 1'b0;
		i_wb_data = '0;
		lcg_state = 32'd95;
		replies_done = 0;
		cycles = 0;
		cycle_limit = 0;
		errors = 0;
		n_pass = 0;
		n_fail = 0;
		model_gpio = '0;
		// memory pattern built from the full word index
		for (i = 0; i < 16; i++)
			mem[i] = 32'hC0DE_0000 + i * 32'h0000_0101;

		$readmemh("netdbg_stim.txt", stim);
		n_words = 0;
		p = 0;
		while (p < STIM_DEPTH && stim[p][35:32] != TAG_END)
		begin
			if (stim[p][35:32] >= TAG_REQ && stim[p][35:32] <= TAG_EXP_LAST)
				n_words++;
			p++;
		end
		cycle_limit = 20 + n_words * CYC_PER_WORD + (1 << LGWD);

		while (i_reset)
			@(posedge i_clk);

		p = 0;
		t = 0;
		while (stim[p][35:32] == TAG_GPIO)
		begin
			fails_before = errors;
			i_gpio <= stim[p][7:0];
			p++;
			first = 1'b1;
			tag = stim[p][35:32];
			while (tag == TAG_REQ || tag == TAG_REQ_LAST)
			begin
				w = stim[p][31:0];
				// the header's masked bits take the new values
				if (first)
					model_gpio = (model_gpio & ~w[15:8]) | (w[7:0] & w[15:8]);
				first = 1'b0;
				send_word(w, tag == TAG_REQ_LAST);
				p++;
				tag = stim[p][35:32];
			end
			i_s_valid <= 1'b0;
			i_s_last <= 1'b0;

			n_exp = 0;
			while ((tag == TAG_EXP || tag == TAG_EXP_LAST) && n_exp < MAX_REPLY)
			begin
				exp_w[n_exp] = {tag == TAG_EXP_LAST, stim[p][31:0]};
				n_exp++;
				p++;
				tag = stim[p][35:32];
			end

			while (replies_done <= t)
				@(posedge i_clk);

			assert (got_q.size() == n_exp)
			else
			begin
				$display("MISMATCH at %0t: test %0d reply has %0d words, expected %0d",
					$time, t + 1, got_q.size(), n_exp);
				errors++;
			end
			for (i = 0; i < n_exp && got_q.size() > 0; i++)
			begin
				got = got_q.pop_front();
				assert (got == exp_w[i])
				else
				begin
					$display("MISMATCH at %0t: test %0d word %0d got %h/%b, expected %h/%b",
						$time, t + 1, i, got[31:0], got[32], exp_w[i][31:0], exp_w[i][32]);
					errors++;
				end
			end
			got_q.delete();
			assert (o_gpio == model_gpio)
			else
			begin
				$display("MISMATCH at %0t: test %0d o_gpio is %h, expected %h",
					$time, t + 1, o_gpio, model_gpio);
				errors++;
			end

			t++;
			if (errors == fails_before)
			begin
				$display("test %0d passed, %0d reply words", t, n_exp);
				n_pass++;
			end
			else
			begin
				$display("test %0d failed", t);
				n_fail++;
			end
		end

		assert (t > 0)
		else
		begin
			$display("ERROR: the stim file held no tests");
			errors++;
		end
		$display("tests %0d, passed %0d, failed %0d, errors %0d", t, n_pass, n_fail, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

//--- tb_clkgen.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////
// testbench clock and a reset released on a rising edge
//////////////////////////////////////////////////
module tb_clkgen #(
	parameter int PERIOD = 40,
	parameter int RESET_CYCLES = 4
) (
	output logic o_clk,
	output logic o_reset
);

	initial
	begin
		o_clk = 1'b0;
		forever
			#(PERIOD / 2) o_clk = ~o_clk;
	end

	// reset held for a whole number of cycles
	initial
	begin
		o_reset = 1'b1;
		repeat (RESET_CYCLES)
			@(posedge o_clk);
		o_reset <= 1'b0;
	end

endmodule

//--- netdbg_top.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////
// debug bridge top level that chains the parser,
// executor, result FIFO and framer
//////////////////////////////////////////////////
module netdbg_top #(
	parameter int AW = 30,
	parameter int LGWATCHDOG = 20,
	parameter int LGFIFO = 4,
	parameter netdbg_pkg::gpio_t DEF_GPIO = '0
) (
	input  logic                  i_clk,
	input  logic                  i_reset,
	// request stream
	input  logic                  i_s_valid,
	output logic                  o_s_ready,
	input  netdbg_pkg::dbg_word_t i_s_data,
	input  logic                  i_s_last,
	// reply stream
	output logic                  o_m_valid,
	input  logic                  i_m_ready,
	output netdbg_pkg::dbg_word_t o_m_data,
	output logic                  o_m_last,
	// wishbone master
	output logic                  o_wb_cyc,
	output logic                  o_wb_stb,
	output logic                  o_wb_we,
	output logic [AW-1:0]         o_wb_addr,
	output netdbg_pkg::dbg_word_t o_wb_data,
	input  logic                  i_wb_stall,
	input  logic                  i_wb_ack,
	input  netdbg_pkg::dbg_word_t i_wb_data,
	input  logic                  i_wb_err,
	// gpio
	input  netdbg_pkg::gpio_t     i_gpio,
	output netdbg_pkg::gpio_t     o_gpio
);
	import netdbg_pkg::*;

	logic cmd_valid, cmd_ready, info_stb, reply_done, bus_err;
	logic res_valid, res_ready, fifo_valid, fifo_ready;
	cmd_item_t cmd;
	pkt_info_t info;
	result_item_t res, fifo_item;

	//////////////////////////////////////////////////
	// request side
	dbg_rx_header #(.DEF_GPIO(DEF_GPIO)) u_rx (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_s_valid(i_s_valid), .o_s_ready(o_s_ready),
		.i_s_data(i_s_data), .i_s_last(i_s_last),
		.o_cmd_valid(cmd_valid), .i_cmd_ready(cmd_ready), .o_cmd(cmd),
		.o_info_stb(info_stb), .o_info(info),
		.i_reply_done(reply_done), .o_gpio(o_gpio)
	);

	dbg_bus_exec #(.AW(AW), .LGWATCHDOG(LGWATCHDOG)) u_exec (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_cmd_valid(cmd_valid), .o_cmd_ready(cmd_ready), .i_cmd(cmd),
		.o_res_valid(res_valid), .i_res_ready(res_ready), .o_res(res),
		.o_bus_err(bus_err),
		.o_wb_cyc(o_wb_cyc), .o_wb_stb(o_wb_stb), .o_wb_we(o_wb_we),
		.o_wb_addr(o_wb_addr), .o_wb_data(o_wb_data),
		.i_wb_stall(i_wb_stall), .i_wb_ack(i_wb_ack),
		.i_wb_data(i_wb_data), .i_wb_err(i_wb_err)
	);

	//////////////////////////////////////////////////
	// reply side
	dbg_result_fifo #(.LGFIFO(LGFIFO)) u_fifo (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_wr_valid(res_valid), .o_wr_ready(res_ready), .i_wr_item(res),
		.o_rd_valid(fifo_valid), .i_rd_ready(fifo_ready), .o_rd_item(fifo_item)
	);

	dbg_tx_framer u_tx (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_info_stb(info_stb), .i_info(info),
		.i_gpio(i_gpio), .i_bus_err(bus_err),
		.i_res_valid(fifo_valid), .o_res_ready(fifo_ready), .i_res(fifo_item),
		.o_m_valid(o_m_valid), .i_m_ready(i_m_ready),
		.o_m_data(o_m_data), .o_m_last(o_m_last),
		.o_reply_done(reply_done)
	);

endmodule

//--- dbg_tx_framer.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////
// reply builder that sends two header words and then
// the results up to the item marked last
//////////////////////////////////////////////////
module dbg_tx_framer (
	input  logic                     i_clk,
	input  logic                     i_reset,
	input  logic                     i_info_stb,
	input  netdbg_pkg::pkt_info_t    i_info,
	input  netdbg_pkg::gpio_t        i_gpio,
	input  logic                     i_bus_err,
	input  logic                     i_res_valid,
	output logic                     o_res_ready,
	input  netdbg_pkg::result_item_t i_res,
	output logic                     o_m_valid,
	input  logic                     i_m_ready,
	output netdbg_pkg::dbg_word_t    o_m_data,
	output logic                     o_m_last,
	output logic                     o_reply_done
);
	import netdbg_pkg::*;

	typedef enum logic [1:0]
	{
		TX_IDLE,
		TX_W0,
		TX_BODY,
		TX_LAST
	} tx_state_e;

	tx_state_e r_state;
	logic r_err, r_err_clr, w_marker, w_skip, w_xfer;
	gpio_t w_status;
	dbg_word_t r_word, r_word1;

	// status byte is the gpio inputs with the sticky error folded in
	always_comb
	begin
		w_status = i_gpio;
		w_status[GPIO_ERR_BIT] = i_gpio[GPIO_ERR_BIT] | r_err;
	end

	// looking one item ahead decides whether the held word is the last one
	assign w_marker = i_res.last && !i_res.has_data;
	assign w_skip = !i_res.last && !i_res.has_data;

	always_comb
	begin
		o_m_valid = 1'b0;
		o_m_last = 1'b0;
		case (r_state)
		TX_W0:
			o_m_valid = 1'b1;
		TX_BODY:
		begin
			o_m_valid = i_res_valid && !w_skip;
			o_m_last = w_marker;
		end
		TX_LAST:
		begin
			o_m_valid = 1'b1;
			o_m_last = 1'b1;
		end
		default:
		begin
		end
		endcase
	end

	assign o_m_data = r_word;
	assign w_xfer = o_m_valid && i_m_ready;
	// the lookahead item is consumed with the held word
	assign o_res_ready = (r_state == TX_BODY) && (i_m_ready || w_skip);
	assign o_reply_done = w_xfer && o_m_last;

	always_ff @(posedge i_clk)
		if (i_reset)
		begin
			r_state <= TX_IDLE;
			r_err <= 1'b0;
			r_err_clr <= 1'b0;
		end
		else
		begin
			// clear request from the host beats a new error
			if (r_err_clr)
				r_err <= 1'b0;
			else if (i_bus_err)
				r_err <= 1'b1;
			case (r_state)
			TX_IDLE:
				if (i_info_stb)
				begin
					r_err_clr <= i_info.gpio[GPIO_ERR_BIT];
					r_state <= TX_W0;
				end
			TX_W0:
				if (i_m_ready)
					r_state <= TX_BODY;
			TX_BODY:
				if (w_xfer)
				begin
					if (w_marker)
						r_state <= TX_IDLE;
					else if (i_res.last)
						r_state <= TX_LAST;
				end
			default:
				if (i_m_ready)
					r_state <= TX_IDLE;
			endcase
		end

	always_ff @(posedge i_clk)
		if (r_state == TX_IDLE && i_info_stb)
		begin
			r_word <= {i_info.frame_id, w_status, i_info.gpio};
			r_word1 <= {i_info.prior_id, i_info.count};
		end
		else if (r_state == TX_W0 && i_m_ready)
			r_word <= r_word1;
		else if (r_state == TX_BODY && w_xfer)
			r_word <= i_res.data;

	// reply word and its last flag hold through back-pressure
	a_reply_hold: assert property (@(posedge i_clk) disable iff (i_reset)
		o_m_valid && !i_m_ready |=> o_m_valid && $stable(o_m_data) && $stable(o_m_last));

endmodule

//--- dbg_result_fifo.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////
// result item FIFO between executor and framer
//////////////////////////////////////////////////
module dbg_result_fifo #(
	parameter int LGFIFO = 4
) (
	input  logic                     i_clk,
	input  logic                     i_reset,
	input  logic                     i_wr_valid,
	output logic                     o_wr_ready,
	input  netdbg_pkg::result_item_t i_wr_item,
	output logic                     o_rd_valid,
	input  logic                     i_rd_ready,
	output netdbg_pkg::result_item_t o_rd_item
);
	import netdbg_pkg::*;

	localparam int DEPTH = 1 << LGFIFO;

	result_item_t mem [DEPTH];
	logic [LGFIFO-1:0] r_wr_ptr, r_rd_ptr;
	logic [LGFIFO:0] r_fill;
	logic w_wr, w_rd;

	assign o_wr_ready = (r_fill != DEPTH);
	assign o_rd_valid = (r_fill != '0);
	// head of the queue is read straight from the array
	assign o_rd_item = mem[r_rd_ptr];
	assign w_wr = i_wr_valid && o_wr_ready;
	assign w_rd = o_rd_valid && i_rd_ready;

	always_ff @(posedge i_clk)
		if (w_wr)
			mem[r_wr_ptr] <= i_wr_item;

	always_ff @(posedge i_clk)
		if (i_reset)
		begin
			r_wr_ptr <= '0;
			r_rd_ptr <= '0;
			r_fill <= '0;
		end
		else
		begin
			if (w_wr)
				r_wr_ptr <= r_wr_ptr + 1'b1;
			if (w_rd)
				r_rd_ptr <= r_rd_ptr + 1'b1;
			if (w_wr && !w_rd)
				r_fill <= r_fill + 1'b1;
			else if (w_rd && !w_wr)
				r_fill <= r_fill - 1'b1;
		end

	// overrun or underrun would break the pointer and count agreement
	a_fill_max: assert property (@(posedge i_clk) disable iff (i_reset)
		r_fill <= DEPTH);
	a_ptr_sync: assert property (@(posedge i_clk) disable iff (i_reset)
		(r_wr_ptr - r_rd_ptr) == r_fill[LGFIFO-1:0]);

endmodule

//--- dbg_bus_exec.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////
// runs each command as one wishbone cycle and
// pushes read results and end markers
//////////////////////////////////////////////////
module dbg_bus_exec #(
	parameter int AW = 30,
	parameter int LGWATCHDOG = 20
) (
	input  logic                     i_clk,
	input  logic                     i_reset,
	input  logic                     i_cmd_valid,
	output logic                     o_cmd_ready,
	input  netdbg_pkg::cmd_item_t    i_cmd,
	output logic                     o_res_valid,
	input  logic                     i_res_ready,
	output netdbg_pkg::result_item_t o_res,
	output logic                     o_bus_err,
	output logic                     o_wb_cyc,
	output logic                     o_wb_stb,
	output logic                     o_wb_we,
	output logic [AW-1:0]            o_wb_addr,
	output netdbg_pkg::dbg_word_t    o_wb_data,
	input  logic                     i_wb_stall,
	input  logic                     i_wb_ack,
	input  netdbg_pkg::dbg_word_t    i_wb_data,
	input  logic                     i_wb_err
);
	import netdbg_pkg::*;

	typedef enum logic [1:0]
	{
		EX_IDLE,
		EX_WDATA,
		EX_BUS,
		EX_PUSH
	} ex_state_e;

	ex_state_e r_state;
	dbg_op_e w_op;
	logic r_last, w_expired, w_done;
	logic [LGWATCHDOG-1:0] r_wdt;
	dbg_word_t w_rd_word;

	assign w_op = dbg_op_e'(i_cmd.data[31:30]);
	assign o_cmd_ready = (r_state == EX_IDLE) || (r_state == EX_WDATA);
	assign o_res_valid = (r_state == EX_PUSH);

	// ack wins over err, err over the watchdog
	assign w_expired = &r_wdt;
	assign w_done = i_wb_ack || i_wb_err || w_expired;
	assign w_rd_word = i_wb_ack ? i_wb_data : (i_wb_err ? DBG_ERR_WORD : DBG_TIMEOUT_WORD);

	always_ff @(posedge i_clk)
		if (i_reset)
		begin
			r_state <= EX_IDLE;
			o_wb_cyc <= 1'b0;
			o_wb_stb <= 1'b0;
		end
		else
			case (r_state)
			EX_IDLE:
				if (i_cmd_valid)
				begin
					o_wb_addr <= i_cmd.data[AW-1:0];
					r_last <= i_cmd.last;
					// preload an end marker for the no-data cases
					o_res <= '{has_data: 1'b0, last: 1'b1, data: '0};
					case (w_op)
					DBG_READ:
					begin
						o_wb_cyc <= 1'b1;
						o_wb_stb <= 1'b1;
						o_wb_we <= 1'b0;
						r_state <= EX_BUS;
					end
					DBG_WRITE:
						// packet ended before the data word, so drop it
						r_state <= i_cmd.last ? EX_PUSH : EX_WDATA;
					default:
						if (i_cmd.last)
							r_state <= EX_PUSH;
					endcase
				end
			EX_WDATA:
				if (i_cmd_valid)
				begin
					o_wb_data <= i_cmd.data;
					r_last <= i_cmd.last;
					o_wb_cyc <= 1'b1;
					o_wb_stb <= 1'b1;
					o_wb_we <= 1'b1;
					r_state <= EX_BUS;
				end
			EX_BUS:
			begin
				// request accepted once stall is low
				if (!i_wb_stall)
					o_wb_stb <= 1'b0;
				if (w_done)
				begin
					o_wb_cyc <= 1'b0;
					o_wb_stb <= 1'b0;
					if (!o_wb_we)
					begin
						o_res <= '{has_data: 1'b1, last: r_last, data: w_rd_word};
						r_state <= EX_PUSH;
					end
					else
						r_state <= r_last ? EX_PUSH : EX_IDLE;
				end
			end
			default:
				if (i_res_ready)
					r_state <= EX_IDLE;
			endcase

	// watchdog counts only while a cycle is open
	always_ff @(posedge i_clk)
		if (i_reset || !o_wb_cyc)
			r_wdt <= '0;
		else
			r_wdt <= r_wdt + 1'b1;

	always_ff @(posedge i_clk)
		if (i_reset)
			o_bus_err <= 1'b0;
		else
			o_bus_err <= o_wb_cyc && i_wb_err;

	a_stb_in_cyc: assert property (@(posedge i_clk) disable iff (i_reset)
		o_wb_stb |-> o_wb_cyc);

endmodule

//--- dbg_rx_header.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////
// request parser that takes gpio and packet info from the
// header word and passes the later words on as command items
//////////////////////////////////////////////////
module dbg_rx_header #(
	parameter netdbg_pkg::gpio_t DEF_GPIO = '0
) (
	input  logic                  i_clk,
	input  logic                  i_reset,
	input  logic                  i_s_valid,
	output logic                  o_s_ready,
	input  netdbg_pkg::dbg_word_t i_s_data,
	input  logic                  i_s_last,
	output logic                  o_cmd_valid,
	input  logic                  i_cmd_ready,
	output netdbg_pkg::cmd_item_t o_cmd,
	output logic                  o_info_stb,
	output netdbg_pkg::pkt_info_t o_info,
	input  logic                  i_reply_done,
	output netdbg_pkg::gpio_t     o_gpio
);
	import netdbg_pkg::*;

	typedef enum logic [1:0]
	{
		RX_HEADER,
		RX_CMDS,
		RX_REPLY
	} rx_state_e;

	rx_state_e r_state, w_next;
	logic r_hdr_open, w_xfer, w_hdr_xfer;
	frame_id_t r_last_id, w_id;
	gpio_t w_mask, w_vals, w_gpio_new;
	pkt_count_t r_count, w_count_next;

	// header fields
	assign w_id = i_s_data[31:16];
	assign w_mask = i_s_data[15:8];
	assign w_vals = i_s_data[7:0];
	// masked bits take the new value and the rest hold
	assign w_gpio_new = (o_gpio & ~w_mask) | (w_vals & w_mask);
	assign w_count_next = r_count + 1'b1;

	// command words pass only when the item register is free
	assign o_s_ready = r_hdr_open || (r_state == RX_CMDS && (!o_cmd_valid || i_cmd_ready));
	assign w_xfer = i_s_valid && o_s_ready;
	assign w_hdr_xfer = w_xfer && r_state == RX_HEADER;

	always_comb
	begin
		w_next = r_state;
		case (r_state)
		RX_HEADER:
			if (w_xfer)
				w_next = i_s_last ? RX_REPLY : RX_CMDS;
		RX_CMDS:
			if (w_xfer && i_s_last)
				w_next = RX_REPLY;
		default:
			// closed until the reply has gone out
			if (i_reply_done)
				w_next = RX_HEADER;
		endcase
	end

	always_ff @(posedge i_clk)
		if (i_reset)
		begin
			r_state <= RX_HEADER;
			r_hdr_open <= 1'b0;
			o_gpio <= DEF_GPIO;
			r_last_id <= '0;
			r_count <= '0;
			o_info_stb <= 1'b0;
			o_cmd_valid <= 1'b0;
		end
		else
		begin
			r_state <= w_next;
			// header ready trails the state by a cycle and is low in reset
			r_hdr_open <= (w_next == RX_HEADER);
			o_info_stb <= w_hdr_xfer;
			if (w_hdr_xfer)
			begin
				o_gpio <= w_gpio_new;
				r_last_id <= w_id;
				r_count <= w_count_next;
			end
			// header-only packet still sends one closing nop
			if (w_xfer && (r_state == RX_CMDS || i_s_last))
				o_cmd_valid <= 1'b1;
			else if (i_cmd_ready)
				o_cmd_valid <= 1'b0;
		end

	always_ff @(posedge i_clk)
	begin
		if (w_hdr_xfer)
			o_info <= '{frame_id: w_id, prior_id: r_last_id,
				count: w_count_next, gpio: w_gpio_new};
		if (w_xfer && r_state == RX_CMDS)
			o_cmd <= '{data: i_s_data, last: i_s_last};
		else if (w_hdr_xfer && i_s_last)
			o_cmd <= '{data: {DBG_NOP, 30'd0}, last: 1'b1};
	end

	// the executor may see the item many cycles after it was offered
	a_cmd_hold: assert property (@(posedge i_clk) disable iff (i_reset)
		o_cmd_valid && !i_cmd_ready |=> o_cmd_valid && $stable(o_cmd));

endmodule

//--- netdbg_pkg.sv
//////////////////////////////////////////////////
// widths, opcodes, result codes and stream items
// shared by every block of the debug bridge
//////////////////////////////////////////////////
package netdbg_pkg;

	// stream words and bus data are the same width
	typedef logic [31:0] dbg_word_t;
	typedef logic [15:0] frame_id_t;
	typedef logic [7:0] gpio_t;
	typedef logic [15:0] pkt_count_t;

	// opcode sits in bits 31:30 of a command word
	typedef enum logic [1:0]
	{
		DBG_NOP   = 2'b00,
		DBG_READ  = 2'b01,
		DBG_WRITE = 2'b10,
		DBG_RSV   = 2'b11
	} dbg_op_e;

	// one request word on its way to the executor
	typedef struct packed
	{
		dbg_word_t data;
		logic      last;
	} cmd_item_t;

	// has_data clear means a bare end-of-packet marker
	typedef struct packed
	{
		logic      has_data;
		logic      last;
		dbg_word_t data;
	} result_item_t;

	// what the reply header needs to know about a packet
	typedef struct packed
	{
		frame_id_t  frame_id;
		frame_id_t  prior_id;
		pkt_count_t count;
		gpio_t      gpio;
	} pkt_info_t;

	localparam dbg_word_t DBG_ERR_WORD = 32'hDEAD_BEEF;
	localparam dbg_word_t DBG_TIMEOUT_WORD = 32'hDEAD_0000;

	// output bit that clears the error flag, status bit that shows it
	localparam int GPIO_ERR_BIT = 2;

endpackage
